//--- flist.f
+incdir+design
design/sd_cmd_pkg.sv
design/sd_cmd_regs.sv
design/sd_cmd_serial.sv
design/sd_cmd_status.sv
design/sd_cmd_ctrl.sv
tests/tb_sd_cmd.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_sd_cmd -f flist.f -o Vtb_sd_cmd
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sd_cmd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/tb_sd_cmd.sv
`timescale 1ns/1ns
`default_nettype none
`include "sd_cmd_defines.svh"

module tb_sd_cmd;

    import sd_cmd_pkg::*;

    // slowest divisor used by the tests is the reset value
    localparam int MAX_DIV     = `SD_CLK_DIV_RST;
    localparam int CYCLE_LIMIT = 30 * 200 * 2 * (MAX_DIV + 1);

    logic                      aclk;
    logic                      arst_n;
    logic [`SD_APB_ADDR_W-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`SD_ARG_W-1:0]      pwdata;
    logic [`SD_ARG_W-1:0]      prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      sd_clk;
    logic                      sd_cmd_out;
    logic                      sd_cmd_oe;
    logic                      sd_cmd_in;
    logic                      irq;

    logic [`SD_FRAME_LEN-1:0]  exp_frame;
    logic [`SD_ARG_W-1:0]      resp_status;
    logic [31:0]               rng_state;
    logic                      answer;
    logic                      bad_crc;
    logic                      bad_index;
    int                        frames_seen = 0;
    int                        cycle_count = 0;

    sd_cmd_ctrl dut_i (
        .aclk_i      (aclk),
        .arst_n_i    (arst_n),
        .paddr_i     (paddr),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd_out),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (sd_cmd_in),
        .interrupt_o (irq)
    );

    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: commands did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // x^7 + x^3 + 1 with zero start and msb first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    function automatic logic [47:0] expected_frame(input logic [5:0] index,
                                                   input logic [31:0] arg);
        logic [39:0] head;
        head = {2'b01, index, arg};
        return {head, crc7(head), 1'b1};
    endfunction

    function automatic logic [47:0] response_frame(input logic [5:0] index,
                                                   input logic [31:0] status,
                                                   input logic crc_bad);
        logic [39:0] body;
        logic [6:0]  crc;
        body = {2'b00, index, status};
        crc  = crc7(body);
        if (crc_bad) begin
            crc = crc ^ 7'h01;
        end
        return {body, crc, 1'b1};
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge aclk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge aclk);
        penable <= 1'b1;
        @(negedge aclk);
        err = pslverr;
        check("pready in write access", 64'(1), 64'(pready));
        @(posedge aclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge aclk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge aclk);
        penable <= 1'b1;
        @(negedge aclk);
        data = prdata;
        err  = pslverr;
        check("pready in read access", 64'(1), 64'(pready));
        @(posedge aclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("register write error", 64'(0), 64'(err));
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check("register read error", 64'(0), 64'(err));
        check(name, 64'(expected), 64'(data));
    endtask

    task automatic run_command(input logic [5:0] index, input logic [31:0] arg,
                               input resp_type_e rtype);
        exp_frame = expected_frame(index, arg);
        write_reg(`SD_REG_INT_STATUS, 32'hF);
        write_reg(`SD_REG_ARGUMENT, arg);
        write_reg(`SD_REG_COMMAND, {22'd0, rtype, 2'd0, index});
    endtask

    task automatic wait_complete(output logic [3:0] status);
        logic [31:0] data;
        logic        err;
        data = '0;
        while (data[0] == 1'b0) begin
            apb_read(`SD_REG_INT_STATUS, data, err);
            check("int_status read error", 64'(0), 64'(err));
        end
        status = data[3:0];
    endtask

    // card model compares each frame and answers when asked to
    initial begin : card_model
        logic [47:0] shift;
        logic [47:0] resp;
        logic [5:0]  resp_index;
        int          nbits;
        sd_cmd_in = 1'b1;
        shift     = '0;
        nbits     = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe) begin
                shift = {shift[46:0], sd_cmd_out};
                nbits++;
                if (nbits == `SD_FRAME_LEN) begin
                    nbits = 0;
                    frames_seen++;
                    check("command frame", 64'(exp_frame), 64'(shift));
                    if (answer) begin
                        resp_index = bad_index ? shift[45:40] ^ 6'h01 : shift[45:40];
                        resp = response_frame(resp_index, resp_status, bad_crc);
                        repeat (2) @(posedge sd_clk);
                        for (int i = 47; i >= 0; i--) begin
                            @(negedge sd_clk);
                            sd_cmd_in <= resp[i];
                        end
                        @(negedge sd_clk);
                        sd_cmd_in <= 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main_seq
        logic [31:0] rdata;
        logic [31:0] arg;
        logic [5:0]  index;
        logic [3:0]  status;
        logic        err;
        int          frames_before;

        aclk        = 1'b0;
        arst_n      = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        answer      = 1'b0;
        bad_crc     = 1'b0;
        bad_index   = 1'b0;
        resp_status = '0;
        exp_frame   = '0;
        rng_state   = 32'h170a1640;
        repeat (5) @(posedge aclk);
        arst_n <= 1'b1;

        // register access
        read_expect(`SD_REG_CLK_DIV, 32'd4, "clk_div reset value");
        rng_state = lcg_next(rng_state);
        write_reg(`SD_REG_ARGUMENT, rng_state);
        read_expect(`SD_REG_ARGUMENT, rng_state, "argument readback");
        write_reg(`SD_REG_CLK_DIV, 32'h5A);
        read_expect(`SD_REG_CLK_DIV, 32'h5A, "clk_div readback");
        write_reg(`SD_REG_INT_ENABLE, 32'hA);
        read_expect(`SD_REG_INT_ENABLE, 32'hA, "int_enable readback");
        write_reg(`SD_REG_INT_ENABLE, 32'h0);
        apb_read(8'h1C, rdata, err);
        check("unmapped read pslverr", 64'(1), 64'(err));
        apb_write(8'h40, 32'h1, err);
        check("unmapped write pslverr", 64'(1), 64'(err));

        // frames without response at two divisors
        for (int d = 0; d < 2; d++) begin
            write_reg(`SD_REG_CLK_DIV, (d == 0) ? 32'd0 : 32'd3);
            for (int n = 0; n < 4; n++) begin
                rng_state = lcg_next(rng_state);
                index     = rng_state[29:24];
                rng_state = lcg_next(rng_state);
                arg       = rng_state;
                run_command(index, arg, RESP_NONE);
                wait_complete(status);
                check("no response status", 64'(4'b0001), 64'(status));
            end
        end

        // good short response
        answer      = 1'b1;
        rng_state   = lcg_next(rng_state);
        resp_status = rng_state;
        rng_state   = lcg_next(rng_state);
        run_command(rng_state[13:8], rng_state, RESP_SHORT);
        wait_complete(status);
        check("short response status", 64'(4'b0001), 64'(status));
        read_expect(`SD_REG_RESPONSE, resp_status, "response register");
        @(negedge aclk);
        check("irq masked", 64'(0), 64'(irq));
        write_reg(`SD_REG_INT_ENABLE, 32'h1);
        @(negedge aclk);
        check("irq enabled", 64'(1), 64'(irq));
        write_reg(`SD_REG_INT_ENABLE, 32'hE);
        @(negedge aclk);
        check("irq other bits enabled", 64'(0), 64'(irq));
        write_reg(`SD_REG_INT_STATUS, 32'h1);
        read_expect(`SD_REG_INT_STATUS, 32'h0, "int_status cleared");
        write_reg(`SD_REG_INT_ENABLE, 32'h0);

        // silent card
        answer = 1'b0;
        run_command(6'd8, 32'h000001AA, RESP_SHORT);
        wait_complete(status);
        check("timeout status", 64'(4'b0011), 64'(status));

        // corrupted responses
        answer  = 1'b1;
        bad_crc = 1'b1;
        run_command(6'd13, 32'h00010000, RESP_SHORT);
        wait_complete(status);
        check("crc error status", 64'(4'b0101), 64'(status));
        bad_crc   = 1'b0;
        bad_index = 1'b1;
        run_command(6'd55, 32'h00020000, RESP_SHORT);
        wait_complete(status);
        check("index error status", 64'(4'b1001), 64'(status));
        bad_index = 1'b0;

        // second command while busy
        frames_before = frames_seen;
        run_command(6'd17, 32'h00001234, RESP_SHORT);
        apb_read(`SD_REG_PRESENT, rdata, err);
        check("present busy", 64'(1), 64'(rdata[0]));
        apb_write(`SD_REG_COMMAND, {22'd0, RESP_NONE, 2'd0, 6'd46}, err);
        check("command while busy pslverr", 64'(1), 64'(err));
        wait_complete(status);
        check("busy command status", 64'(4'b0001), 64'(status));
        check("frames per command", 64'(frames_before + 1), 64'(frames_seen));
        read_expect(`SD_REG_PRESENT, 32'h0, "present idle");

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/sd_cmd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "sd_cmd_defines.svh"

module sd_cmd_ctrl (
    input  wire                      aclk_i,
    input  wire                      arst_n_i,
    input  wire [`SD_APB_ADDR_W-1:0] paddr_i,
    input  wire                      psel_i,
    input  wire                      penable_i,
    input  wire                      pwrite_i,
    input  wire [`SD_ARG_W-1:0]      pwdata_i,
    output wire [`SD_ARG_W-1:0]      prdata_o,
    output wire                      pready_o,
    output wire                      pslverr_o,
    output wire                      sd_clk_o,
    output wire                      sd_cmd_o,
    output wire                      sd_cmd_oe_o,
    input  wire                      sd_cmd_i,
    output wire                      interrupt_o
);

    import sd_cmd_pkg::*;

    cmd_req_t             cmd_req;
    cmd_result_t          cmd_result;
    int_status_t          int_clear;
    int_status_t          int_enable;
    int_status_t          int_status;
    logic                 cmd_start;
    logic                 cmd_busy;
    logic                 cmd_done;
    logic [`SD_DIV_W-1:0] clk_div;
    logic [`SD_ARG_W-1:0] response;

    sd_cmd_regs regs_i (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .cmd_busy_i   (cmd_busy),
        .int_status_i (int_status),
        .response_i   (response),
        .cmd_req_o    (cmd_req),
        .cmd_start_o  (cmd_start),
        .clk_div_o    (clk_div),
        .int_clear_o  (int_clear),
        .int_enable_o (int_enable)
    );

    sd_cmd_serial serial_i (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .clk_div_i    (clk_div),
        .cmd_req_i    (cmd_req),
        .cmd_start_i  (cmd_start),
        .sd_cmd_i     (sd_cmd_i),
        .sd_clk_o     (sd_clk_o),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe_o  (sd_cmd_oe_o),
        .cmd_busy_o   (cmd_busy),
        .cmd_done_o   (cmd_done),
        .cmd_result_o (cmd_result)
    );

    sd_cmd_status status_i (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .cmd_done_i   (cmd_done),
        .cmd_result_i (cmd_result),
        .int_clear_i  (int_clear),
        .int_enable_i (int_enable),
        .int_status_o (int_status),
        .response_o   (response),
        .interrupt_o  (interrupt_o)
    );

endmodule

`default_nettype wire

//--- design/sd_cmd_status.sv
`timescale 1ns/1ns
`default_nettype none
`include "sd_cmd_defines.svh"

module sd_cmd_status (
    input  wire                          aclk_i,
    input  wire                          arst_n_i,
    input  wire                          cmd_done_i,
    input  wire sd_cmd_pkg::cmd_result_t cmd_result_i,
    input  wire sd_cmd_pkg::int_status_t int_clear_i,
    input  wire sd_cmd_pkg::int_status_t int_enable_i,
    output sd_cmd_pkg::int_status_t      int_status_o,
    output logic [`SD_ARG_W-1:0]         response_o,
    output logic                         interrupt_o
);

    import sd_cmd_pkg::*;

    int_status_t set_bits;

    always_comb begin
        set_bits = '0;
        if (cmd_done_i) begin
            set_bits.complete  = 1'b1;
            set_bits.timeout   = cmd_result_i.timeout;
            set_bits.crc_err   = cmd_result_i.has_response & !cmd_result_i.crc_ok;
            set_bits.index_err = cmd_result_i.has_response & !cmd_result_i.index_ok;
        end
    end

    // new events win over a clear in the same cycle
    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            int_status_o <= '0;
        end else begin
            int_status_o <= int_status_t'((int_status_o & ~int_clear_i) | set_bits);
        end
    end

    always_ff @(posedge aclk_i) begin
        if (cmd_done_i && cmd_result_i.has_response) begin
            response_o <= cmd_result_i.card_status;
        end
    end

    assign interrupt_o = |(int_status_o & int_enable_i);

endmodule

`default_nettype wire

//--- design/sd_cmd_serial.sv
`timescale 1ns/1ns
`default_nettype none
`include "sd_cmd_defines.svh"

module sd_cmd_serial (
    input  wire                       aclk_i,
    input  wire                       arst_n_i,
    input  wire [`SD_DIV_W-1:0]       clk_div_i,
    input  wire sd_cmd_pkg::cmd_req_t cmd_req_i,
    input  wire                       cmd_start_i,
    input  wire                       sd_cmd_i,
    output logic                      sd_clk_o,
    output logic                      sd_cmd_o,
    output logic                      sd_cmd_oe_o,
    output logic                      cmd_busy_o,
    output logic                      cmd_done_o,
    output sd_cmd_pkg::cmd_result_t   cmd_result_o
);

    import sd_cmd_pkg::*;

    localparam int HDR_LEN = `SD_FRAME_LEN - `SD_CRC_W - 1;
    localparam int IDX_MSB = `SD_FRAME_LEN - 3;
    localparam int STS_MSB = IDX_MSB - `SD_CMD_INDEX_W;
    localparam int CNT_W   = $clog2(`SD_NCR_MAX > `SD_FRAME_LEN ? `SD_NCR_MAX : `SD_FRAME_LEN + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_WAIT, ST_RECV} state_e;

    state_e                    state;
    logic [`SD_DIV_W-1:0]      div_cnt;
    logic                      tick;
    logic                      rise_tick;
    logic                      fall_tick;
    logic [CNT_W-1:0]          cnt;
    cmd_req_t                  req_q;
    logic [HDR_LEN-1:0]        tx_sr;
    logic [`SD_FRAME_LEN-2:0]  rx_sr;
    logic [`SD_FRAME_LEN-1:0]  rx_frame;
    logic [`SD_CRC_W-1:0]      crc;
    logic                      tx_bit;
    logic                      resp_short;
    logic                      send_end;
    logic                      ncr_expired;
    logic                      recv_last;

    // polynomial x^7 + x^3 + 1
    function automatic logic [`SD_CRC_W-1:0] crc7_step(input logic [`SD_CRC_W-1:0] c,
                                                       input logic din);
        logic fb;
        fb = din ^ c[`SD_CRC_W-1];
        return {c[5:3], c[2] ^ fb, c[1:0], fb};
    endfunction

    // sd clock toggles every clk_div + 1 cycles
    assign tick      = (div_cnt >= clk_div_i);
    assign rise_tick = tick & !sd_clk_o;
    assign fall_tick = tick & sd_clk_o;

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt  <= '0;
            sd_clk_o <= 1'b0;
        end else if (tick) begin
            div_cnt  <= '0;
            sd_clk_o <= ~sd_clk_o;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign resp_short  = (req_q.resp_type == RESP_SHORT);
    assign send_end    = (state == ST_SEND) & fall_tick & (cnt == CNT_W'(`SD_FRAME_LEN));
    assign ncr_expired = (state == ST_WAIT) & rise_tick & sd_cmd_i &
                         (cnt == CNT_W'(`SD_NCR_MAX - 1));
    assign recv_last   = (state == ST_RECV) & rise_tick & (cnt == CNT_W'(`SD_FRAME_LEN - 1));
    assign rx_frame    = {rx_sr, sd_cmd_i};

    // header, then crc, then end bit
    always_comb begin
        if (cnt < CNT_W'(HDR_LEN)) begin
            tx_bit = tx_sr[HDR_LEN-1];
        end else if (cnt < CNT_W'(`SD_FRAME_LEN - 1)) begin
            tx_bit = crc[`SD_CRC_W-1];
        end else begin
            tx_bit = 1'b1;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            cmd_busy_o  <= 1'b0;
            cmd_done_o  <= 1'b0;
            sd_cmd_oe_o <= 1'b0;
            sd_cmd_o    <= 1'b1;
        end else begin
            cmd_done_o <= send_end & !resp_short | ncr_expired | recv_last;
            case (state)
                ST_IDLE: begin
                    if (cmd_start_i) begin
                        state      <= ST_SEND;
                        cnt        <= '0;
                        cmd_busy_o <= 1'b1;
                    end
                end
                ST_SEND: begin
                    if (send_end) begin
                        sd_cmd_oe_o <= 1'b0;
                        sd_cmd_o    <= 1'b1;
                        cnt         <= '0;
                        state       <= resp_short ? ST_WAIT : ST_IDLE;
                        cmd_busy_o  <= resp_short;
                    end else if (fall_tick) begin
                        sd_cmd_oe_o <= 1'b1;
                        sd_cmd_o    <= tx_bit;
                        cnt         <= cnt + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (ncr_expired) begin
                        state      <= ST_IDLE;
                        cmd_busy_o <= 1'b0;
                    end else if (rise_tick && !sd_cmd_i) begin
                        state <= ST_RECV;
                        cnt   <= CNT_W'(1);
                    end else if (rise_tick) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_RECV: begin
                    if (recv_last) begin
                        state      <= ST_IDLE;
                        cmd_busy_o <= 1'b0;
                    end else if (rise_tick) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk_i) begin
        if (state == ST_IDLE && cmd_start_i) begin
            req_q <= cmd_req_i;
            tx_sr <= {1'b0, 1'b1, cmd_req_i.index, cmd_req_i.argument};
            crc   <= '0;
        end
        if (state == ST_SEND && fall_tick && cnt < CNT_W'(HDR_LEN)) begin
            tx_sr <= tx_sr << 1;
            crc   <= crc7_step(crc, tx_sr[HDR_LEN-1]);
        end else if (state == ST_SEND && fall_tick && cnt < CNT_W'(`SD_FRAME_LEN - 1)) begin
            crc <= crc << 1;
        end
        if ((state == ST_WAIT || state == ST_RECV) && rise_tick) begin
            rx_sr <= rx_frame[`SD_FRAME_LEN-2:0];
            // start bit is zero and leaves the crc at zero
            if (state == ST_WAIT) begin
                crc <= '0;
            end else if (cnt < CNT_W'(HDR_LEN)) begin
                crc <= crc7_step(crc, sd_cmd_i);
            end
        end
        if (recv_last) begin
            cmd_result_o.card_status  <= rx_frame[STS_MSB -: `SD_ARG_W];
            cmd_result_o.timeout      <= 1'b0;
            cmd_result_o.crc_ok       <= (rx_frame[`SD_CRC_W:1] == crc);
            cmd_result_o.index_ok     <= (rx_frame[IDX_MSB -: `SD_CMD_INDEX_W] == req_q.index);
            cmd_result_o.has_response <= 1'b1;
            cmd_result_o.spare        <= 1'b0;
        end else if (send_end | ncr_expired) begin
            cmd_result_o         <= '0;
            cmd_result_o.timeout <= ncr_expired;
        end
    end

    a_oe_in_send: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        sd_cmd_oe_o |-> state == ST_SEND);

    a_done_pulse: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        cmd_done_o |=> !cmd_done_o);

endmodule

`default_nettype wire

//--- design/sd_cmd_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "sd_cmd_defines.svh"

module sd_cmd_regs (
    input  wire                          aclk_i,
    input  wire                          arst_n_i,
    input  wire [`SD_APB_ADDR_W-1:0]     paddr_i,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire [`SD_ARG_W-1:0]          pwdata_i,
    output logic [`SD_ARG_W-1:0]         prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire                          cmd_busy_i,
    input  wire sd_cmd_pkg::int_status_t int_status_i,
    input  wire [`SD_ARG_W-1:0]          response_i,
    output sd_cmd_pkg::cmd_req_t         cmd_req_o,
    output logic                         cmd_start_o,
    output logic [`SD_DIV_W-1:0]         clk_div_o,
    output sd_cmd_pkg::int_status_t      int_clear_o,
    output sd_cmd_pkg::int_status_t      int_enable_o
);

    import sd_cmd_pkg::*;

    logic                 access;
    logic                 wr_en;
    logic                 busy;
    logic                 cmd_wr;
    logic                 mapped;
    logic [`SD_ARG_W-1:0] argument_q;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;
    assign cmd_wr = wr_en & (paddr_i == `SD_REG_COMMAND);

    // a launch already pulsed counts as busy too
    assign busy = cmd_busy_i | cmd_start_o;

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `SD_REG_ARGUMENT: prdata_o = argument_q;
            `SD_REG_COMMAND: begin
                prdata_o[`SD_CMD_INDEX_W-1:0] = cmd_req_o.index;
                prdata_o[`SD_CMD_RESP_LSB +: 2] = cmd_req_o.resp_type;
            end
            `SD_REG_CLK_DIV:    prdata_o[`SD_DIV_W-1:0] = clk_div_o;
            `SD_REG_RESPONSE:   prdata_o = response_i;
            `SD_REG_INT_STATUS: prdata_o[`SD_INT_W-1:0] = int_status_i;
            `SD_REG_INT_ENABLE: prdata_o[`SD_INT_W-1:0] = int_enable_o;
            `SD_REG_PRESENT:    prdata_o[0] = cmd_busy_i;
            default:            mapped = 1'b0;
        endcase
    end

    assign pready_o  = access;
    assign pslverr_o = access & (!mapped | (cmd_wr & busy));

    // write one to clear takes effect in the access cycle
    assign int_clear_o = (wr_en && paddr_i == `SD_REG_INT_STATUS) ?
                         int_status_t'(pwdata_i[`SD_INT_W-1:0]) : '0;

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            argument_q   <= '0;
            clk_div_o    <= `SD_DIV_W'(`SD_CLK_DIV_RST);
            int_enable_o <= '0;
            cmd_req_o    <= '0;
            cmd_start_o  <= 1'b0;
        end else begin
            cmd_start_o <= cmd_wr & !busy;
            if (wr_en) begin
                case (paddr_i)
                    `SD_REG_ARGUMENT: argument_q <= pwdata_i;
                    `SD_REG_COMMAND: begin
                        if (!busy) begin
                            cmd_req_o.index     <= pwdata_i[`SD_CMD_INDEX_W-1:0];
                            cmd_req_o.resp_type <= resp_type_e'(pwdata_i[`SD_CMD_RESP_LSB +: 2]);
                            cmd_req_o.argument  <= argument_q;
                        end
                    end
                    `SD_REG_CLK_DIV:    clk_div_o <= pwdata_i[`SD_DIV_W-1:0];
                    `SD_REG_INT_ENABLE: int_enable_o <= int_status_t'(pwdata_i[`SD_INT_W-1:0]);
                    default: ;
                endcase
            end
        end
    end

    // busy rises one cycle after the pulse, so a second launch must wait for done
    a_no_start_busy: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        cmd_start_o |-> !cmd_busy_i);

endmodule

`default_nettype wire

//--- design/sd_cmd_pkg.sv
`default_nettype none
`include "sd_cmd_defines.svh"

package sd_cmd_pkg;

    // 2 and 3 are reserved and handled like no response
    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } resp_type_e;

    typedef struct packed {
        logic [`SD_CMD_INDEX_W-1:0] index;
        resp_type_e                 resp_type;
        logic [`SD_ARG_W-1:0]       argument;
    } cmd_req_t;

    // one per finished command
    typedef struct packed {
        logic [`SD_ARG_W-1:0] card_status;
        logic                 timeout;
        logic                 crc_ok;
        logic                 index_ok;
        logic                 has_response;
        logic                 spare;
    } cmd_result_t;

    // bit 0 is complete
    typedef struct packed {
        logic index_err;
        logic crc_err;
        logic timeout;
        logic complete;
    } int_status_t;

endpackage

`default_nettype wire

//--- design/sd_cmd_defines.svh
`ifndef SD_CMD_DEFINES_SVH
`define SD_CMD_DEFINES_SVH

// APB register map in byte offsets
`define SD_REG_ARGUMENT    8'h00
`define SD_REG_COMMAND     8'h04
`define SD_REG_CLK_DIV     8'h08
`define SD_REG_RESPONSE    8'h0C
`define SD_REG_INT_STATUS  8'h10
`define SD_REG_INT_ENABLE  8'h14
`define SD_REG_PRESENT     8'h18

`define SD_APB_ADDR_W      8

// command register holds the index in the low bits and the response type above
`define SD_CMD_INDEX_W     6
`define SD_CMD_RESP_LSB    8

`define SD_ARG_W           32
`define SD_CRC_W           7
`define SD_FRAME_LEN       48

`define SD_DIV_W           8
`define SD_CLK_DIV_RST     4

// complete, timeout, crc error, index error
`define SD_INT_W           4

// sd clock periods before a missing start bit counts as timeout
`define SD_NCR_MAX         64

`endif
